// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
		--top-module tb_mem_subsys -f verilog.f -o tb_mem_subsys
	./obj_dir/tb_mem_subsys | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: byte_ram.sv
`timescale 1ns/10ps

module byte_ram #(
    parameter int unsigned RAM_ADDR_W = 12
) (
    input  logic                         clk_in,
    input  logic                         r_or_w,
    input  logic [mem_pkg::XLEN-1:0]     a_in,
    input  logic [mem_pkg::BYTE_W-1:0]   d_in,
    output logic [mem_pkg::BYTE_W-1:0]   d_out
);
    import mem_pkg::*;

    localparam int unsigned DEPTH = 2 ** RAM_ADDR_W;

    logic [BYTE_W-1:0]     mem [DEPTH];
    logic [RAM_ADDR_W-1:0] rd_addr_q;

    // memory starts out cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // upper address bits are ignored
    always_ff @(posedge clk_in) begin
        if (r_or_w) begin
            mem[a_in[RAM_ADDR_W-1:0]] <= d_in;
        end
        rd_addr_q <= a_in[RAM_ADDR_W-1:0];
    end

    // read data follows the address of the previous cycle
    assign d_out = mem[rd_addr_q];

endmodule

// File: fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       fetch_en,
    input  logic                       pc_load,
    input  logic [mem_pkg::XLEN-1:0]   pc_value,
    output logic                       instr_valid,
    output logic [mem_pkg::XLEN-1:0]   instr,
    output logic [mem_pkg::XLEN-1:0]   instr_pc,
    // to and from memctrl
    output logic                       if_read_or_not,
    output logic [mem_pkg::XLEN-1:0]   intru_addr,
    input  logic                       if_load_done,
    input  logic [mem_pkg::XLEN-1:0]   mem_ctrl_instru_to_if,
    input  logic [1:0]                 mem_ctrl_busy_state
);
    import mem_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            in_flight_q;
    logic            accept;

    // a done only counts for a fetch we saw memctrl take up
    assign accept     = if_load_done && if_read_or_not && in_flight_q;
    assign intru_addr = pc_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc_q           <= '0;
            if_read_or_not <= 1'b0;
            in_flight_q    <= 1'b0;
            instr_valid    <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            if (pc_load) begin
                // new pc cancels whatever was pending
                pc_q           <= pc_value;
                if_read_or_not <= 1'b0;
                in_flight_q    <= 1'b0;
            end else if (accept) begin
                pc_q           <= pc_q + XLEN'(FETCH_BYTES);
                if_read_or_not <= 1'b0;
                in_flight_q    <= 1'b0;
                instr_valid    <= 1'b1;
            end else begin
                // request goes up one cycle after it was dropped
                if (fetch_en && !if_read_or_not) begin
                    if_read_or_not <= 1'b1;
                end
                if (if_read_or_not && mem_ctrl_busy_state[BUSY_IF]) begin
                    in_flight_q <= 1'b1;
                end
            end
        end
    end

    // instruction word and its pc
    always_ff @(posedge clk_in) begin
        if (accept && !pc_load) begin
            instr    <= mem_ctrl_instru_to_if;
            instr_pc <= pc_q;
        end
    end

endmodule

// File: load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit (
    input  logic                       clk_in,
    input  logic                       rst_in,
    // command side
    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  mem_pkg::mem_size_t         cmd_size,
    input  logic                       cmd_signed,
    input  logic [mem_pkg::XLEN-1:0]   cmd_addr,
    input  logic [mem_pkg::XLEN-1:0]   cmd_wdata,
    output logic                       lsu_busy,
    output logic                       lsu_done,
    output logic [mem_pkg::XLEN-1:0]   lsu_rdata,
    // to and from memctrl
    output logic                       read_mem,
    output logic                       write_mem,
    output logic [mem_pkg::XLEN-1:0]   mem_addr,
    output logic [mem_pkg::XLEN-1:0]   mem_data_to_write,
    output mem_pkg::mem_size_t         data_len,
    input  logic                       mem_load_done,
    input  logic [mem_pkg::XLEN-1:0]   mem_ctrl_load_to_mem,
    input  logic [1:0]                 mem_ctrl_busy_state
);
    import mem_pkg::*;

    logic            signed_q;
    logic            issued_q;
    logic            accept;
    logic            done_ok;
    logic            sign_bit;
    logic [XLEN-1:0] ext_data;

    assign accept  = cmd_valid && !lsu_busy;
    assign done_ok = mem_load_done && issued_q;

    // extend from the top bit of the accessed size
    always_comb begin
        case (data_len)
            SIZE_B: begin
                sign_bit = signed_q && mem_ctrl_load_to_mem[BYTE_W-1];
                ext_data = {{(XLEN-BYTE_W){sign_bit}}, mem_ctrl_load_to_mem[BYTE_W-1:0]};
            end
            SIZE_H: begin
                sign_bit = signed_q && mem_ctrl_load_to_mem[2*BYTE_W-1];
                ext_data = {{(XLEN-2*BYTE_W){sign_bit}},
                            mem_ctrl_load_to_mem[2*BYTE_W-1:0]};
            end
            default: begin
                sign_bit = 1'b0;
                ext_data = mem_ctrl_load_to_mem;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            lsu_busy  <= 1'b0;
            read_mem  <= 1'b0;
            write_mem <= 1'b0;
            issued_q  <= 1'b0;
            lsu_done  <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            if (accept) begin
                lsu_busy  <= 1'b1;
                read_mem  <= !cmd_write;
                write_mem <= cmd_write;
            end else if (done_ok) begin
                lsu_busy  <= 1'b0;
                read_mem  <= 1'b0;
                write_mem <= 1'b0;
                issued_q  <= 1'b0;
                lsu_done  <= 1'b1;
            end else if ((read_mem || write_mem) && mem_ctrl_busy_state[BUSY_MEM]) begin
                // memctrl has taken our request
                issued_q <= 1'b1;
            end
        end
    end

    // command payload and result
    always_ff @(posedge clk_in) begin
        if (accept) begin
            mem_addr          <= cmd_addr;
            mem_data_to_write <= cmd_wdata;
            data_len          <= cmd_size;
            signed_q          <= cmd_signed;
        end
        if (done_ok) begin
            lsu_rdata <= write_mem ? '0 : ext_data;
        end
    end

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // datapath widths
    localparam int unsigned XLEN   = 32;
    localparam int unsigned BYTE_W = 8;

    // access length in bytes
    typedef enum logic [2:0] {
        SIZE_B = 3'd1,
        SIZE_H = 3'd2,
        SIZE_W = 3'd4
    } mem_size_t;

    // every instruction is one full word
    localparam int unsigned FETCH_BYTES = 4;

    // bit positions inside the 2-bit busy state
    localparam int unsigned BUSY_IF  = 1;
    localparam int unsigned BUSY_MEM = 0;

endpackage

// File: mem_subsys_input.txt
// op size signed count addr data
// op 1 store, 2 load (data is the expected value), 3 fetch start, 4 fetch wait, 0 end
1 4 0 0 00000100 11223344
2 4 0 0 00000100 11223344
2 2 0 0 00000102 00001122
2 1 0 0 00000100 00000044
1 2 0 0 00000104 0000a5b6
2 2 0 0 00000104 0000a5b6
2 2 1 0 00000104 ffffa5b6
1 1 0 0 00000106 00000080
2 1 1 0 00000106 ffffff80
2 1 0 0 00000106 00000080
2 4 0 0 00000104 0080a5b6
1 1 0 0 00000101 000000ee
2 4 0 0 00000100 1122ee44
2 1 1 0 00000101 ffffffee
1 1 0 0 00000108 deadbe7f
2 4 0 0 00000108 0000007f
1 2 0 0 0000010c cafe8001
2 4 1 0 0000010c 00008001
2 2 1 0 0000010c ffff8001
1 4 0 0 00000200 00000013
1 4 0 0 00000204 00100093
1 4 0 0 00000208 00208113
1 4 0 0 0000020c 003101b3
1 4 0 0 00000210 fe0008e3
1 4 0 0 00000214 00c12023
3 0 0 6 00000200 00000013
4 0 0 0 00000000 00000000
3 0 0 5 00000204 00100093
1 4 0 0 00000300 89abcdef
2 1 1 0 00000303 ffffff89
2 2 0 0 00000300 0000cdef
1 2 0 0 00000302 00007654
2 4 0 0 00000300 7654cdef
2 2 1 0 00000301 000054cd
2 4 0 0 00000204 00100093
4 0 0 0 00000000 00000000
0 0 0 0 00000000 00000000

// File: mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top #(
    parameter int unsigned RAM_ADDR_W = 12
) (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  logic                       rdy_in,
    // load/store commands
    input  logic                       cmd_valid,
    input  logic                       cmd_write,
    input  mem_pkg::mem_size_t         cmd_size,
    input  logic                       cmd_signed,
    input  logic [mem_pkg::XLEN-1:0]   cmd_addr,
    input  logic [mem_pkg::XLEN-1:0]   cmd_wdata,
    output logic                       lsu_busy,
    output logic                       lsu_done,
    output logic [mem_pkg::XLEN-1:0]   lsu_rdata,
    // instruction stream
    input  logic                       pc_load,
    input  logic [mem_pkg::XLEN-1:0]   pc_value,
    input  logic                       fetch_en,
    output logic                       instr_valid,
    output logic [mem_pkg::XLEN-1:0]   instr,
    output logic [mem_pkg::XLEN-1:0]   instr_pc
);
    import mem_pkg::*;

    // fetch path
    logic              if_read_or_not;
    logic [XLEN-1:0]   intru_addr;
    logic              if_load_done;
    logic [XLEN-1:0]   mem_ctrl_instru_to_if;
    // data path
    logic              read_mem;
    logic              write_mem;
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN-1:0]   mem_data_to_write;
    mem_size_t         data_len;
    logic              mem_load_done;
    logic [XLEN-1:0]   mem_ctrl_load_to_mem;
    logic [1:0]        mem_ctrl_busy_state;
    // RAM port
    logic              r_or_w;
    logic [XLEN-1:0]   ram_addr;
    logic [BYTE_W-1:0] ram_wdata;
    logic [BYTE_W-1:0] ram_rdata;

    fetch_unit fetch_unit_i (
        .clk_in                (clk_in),
        .rst_in                (rst_in),
        .fetch_en              (fetch_en),
        .pc_load               (pc_load),
        .pc_value              (pc_value),
        .instr_valid           (instr_valid),
        .instr                 (instr),
        .instr_pc              (instr_pc),
        .if_read_or_not        (if_read_or_not),
        .intru_addr            (intru_addr),
        .if_load_done          (if_load_done),
        .mem_ctrl_instru_to_if (mem_ctrl_instru_to_if),
        .mem_ctrl_busy_state   (mem_ctrl_busy_state)
    );

    load_store_unit lsu_i (
        .clk_in               (clk_in),
        .rst_in               (rst_in),
        .cmd_valid            (cmd_valid),
        .cmd_write            (cmd_write),
        .cmd_size             (cmd_size),
        .cmd_signed           (cmd_signed),
        .cmd_addr             (cmd_addr),
        .cmd_wdata            (cmd_wdata),
        .lsu_busy             (lsu_busy),
        .lsu_done             (lsu_done),
        .lsu_rdata            (lsu_rdata),
        .read_mem             (read_mem),
        .write_mem            (write_mem),
        .mem_addr             (mem_addr),
        .mem_data_to_write    (mem_data_to_write),
        .data_len             (data_len),
        .mem_load_done        (mem_load_done),
        .mem_ctrl_load_to_mem (mem_ctrl_load_to_mem),
        .mem_ctrl_busy_state  (mem_ctrl_busy_state)
    );

    memctrl memctrl_i (
        .clk_in                (clk_in),
        .rst_in                (rst_in),
        .rdy_in                (rdy_in),
        .mem_ctrl_busy_state   (mem_ctrl_busy_state),
        .mem_load_done         (mem_load_done),
        .mem_ctrl_load_to_mem  (mem_ctrl_load_to_mem),
        .read_mem              (read_mem),
        .write_mem             (write_mem),
        .mem_addr              (mem_addr),
        .mem_data_to_write     (mem_data_to_write),
        .data_len              (data_len),
        .if_load_done          (if_load_done),
        .mem_ctrl_instru_to_if (mem_ctrl_instru_to_if),
        .if_read_or_not        (if_read_or_not),
        .intru_addr            (intru_addr),
        .d_in                  (ram_rdata),
        .r_or_w                (r_or_w),
        .a_out                 (ram_addr),
        .d_out                 (ram_wdata)
    );

    byte_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) ram_i (
        .clk_in (clk_in),
        .r_or_w (r_or_w),
        .a_in   (ram_addr),
        .d_in   (ram_wdata),
        .d_out  (ram_rdata)
    );

endmodule

// File: memctrl.sv
`timescale 1ns/10ps

module memctrl (
    input  logic                        clk_in,
    input  logic                        rst_in,
    input  logic                        rdy_in,
    // busy state to both requesters
    output logic [1:0]                  mem_ctrl_busy_state,
    // data side
    output logic                        mem_load_done,
    output logic [mem_pkg::XLEN-1:0]    mem_ctrl_load_to_mem,
    input  logic                        read_mem,
    input  logic                        write_mem,
    input  logic [mem_pkg::XLEN-1:0]    mem_addr,
    input  logic [mem_pkg::XLEN-1:0]    mem_data_to_write,
    input  mem_pkg::mem_size_t          data_len,
    // fetch side
    output logic                        if_load_done,
    output logic [mem_pkg::XLEN-1:0]    mem_ctrl_instru_to_if,
    input  logic                        if_read_or_not,
    input  logic [mem_pkg::XLEN-1:0]    intru_addr,
    // byte RAM
    input  logic [mem_pkg::BYTE_W-1:0]  d_in,
    output logic                        r_or_w,
    output logic [mem_pkg::XLEN-1:0]    a_out,
    output logic [mem_pkg::BYTE_W-1:0]  d_out
);
    import mem_pkg::*;

    // owner of the RAM port
    localparam logic [1:0] OWN_IDLE  = 2'd0;
    localparam logic [1:0] OWN_FETCH = 2'd1;
    localparam logic [1:0] OWN_READ  = 2'd2;
    localparam logic [1:0] OWN_WRITE = 2'd3;

    logic [1:0]      owner_q;
    logic [2:0]      cnt_q;
    logic [2:0]      last_cnt;
    logic [2:0]      addr_cnt;
    logic [1:0]      byte_sel;
    logic [XLEN-1:0] asm_q;
    logic [XLEN-1:0] asm_next;
    logic [XLEN-1:0] fetch_addr_q;
    logic [XLEN-1:0] base_addr;
    logic            start_ok;
    logic            addr_moved;
    logic            at_last;

    // no new start while a done pulse is still out
    assign start_ok   = (owner_q == OWN_IDLE) && !mem_load_done && !if_load_done;
    assign addr_moved = (intru_addr != fetch_addr_q);
    assign at_last    = (cnt_q == last_cnt);

    // final count of the running transaction
    always_comb begin
        case (owner_q)
            OWN_FETCH: last_cnt = 3'(FETCH_BYTES);
            OWN_READ:  last_cnt = data_len;
            OWN_WRITE: last_cnt = data_len - 3'd1;
            default:   last_cnt = 3'd0;
        endcase
    end

    // byte arriving now belongs to the previous count
    assign byte_sel = cnt_q[1:0] - 2'd1;

    always_comb begin
        asm_next = asm_q;
        if (cnt_q != 3'd0) begin
            asm_next[byte_sel*BYTE_W +: BYTE_W] = d_in;
        end
    end

    // a stalled cycle re-reads the byte still waiting to be captured
    assign addr_cnt = rdy_in ? cnt_q : cnt_q - 3'd1;

    // RAM side
    assign base_addr = (owner_q == OWN_FETCH) ? intru_addr : mem_addr;
    assign a_out     = base_addr + XLEN'(addr_cnt);
    assign d_out     = mem_data_to_write[cnt_q[1:0]*BYTE_W +: BYTE_W];
    assign r_or_w    = rdy_in && (owner_q == OWN_WRITE);

    always_comb begin
        mem_ctrl_busy_state           = 2'b00;
        mem_ctrl_busy_state[BUSY_IF]  = (owner_q == OWN_FETCH);
        mem_ctrl_busy_state[BUSY_MEM] = (owner_q == OWN_READ) || (owner_q == OWN_WRITE);
    end

    // owner, counter and done pulses
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            owner_q       <= OWN_IDLE;
            cnt_q         <= 3'd0;
            mem_load_done <= 1'b0;
            if_load_done  <= 1'b0;
        end else begin
            // pulses last one cycle even under a stall
            mem_load_done <= 1'b0;
            if_load_done  <= 1'b0;
            if (rdy_in) begin
                case (owner_q)
                    OWN_IDLE: begin
                        cnt_q <= 3'd0;
                        if (start_ok) begin
                            // data request beats fetch
                            if (read_mem) begin
                                owner_q <= OWN_READ;
                            end else if (write_mem) begin
                                owner_q <= OWN_WRITE;
                            end else if (if_read_or_not) begin
                                owner_q <= OWN_FETCH;
                            end
                        end
                    end
                    OWN_FETCH: begin
                        if (addr_moved) begin
                            // pc moved under us so the word starts over
                            cnt_q <= 3'd0;
                        end else if (at_last) begin
                            owner_q      <= OWN_IDLE;
                            if_load_done <= 1'b1;
                        end else begin
                            cnt_q <= cnt_q + 3'd1;
                        end
                    end
                    default: begin
                        if (at_last) begin
                            owner_q       <= OWN_IDLE;
                            mem_load_done <= 1'b1;
                        end else begin
                            cnt_q <= cnt_q + 3'd1;
                        end
                    end
                endcase
            end
        end
    end

    // word assembly and returned data
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (owner_q == OWN_IDLE) begin
                asm_q        <= '0;
                fetch_addr_q <= intru_addr;
            end else if ((owner_q == OWN_FETCH) && addr_moved) begin
                asm_q        <= '0;
                fetch_addr_q <= intru_addr;
            end else if (owner_q != OWN_WRITE) begin
                asm_q <= asm_next;
            end

            // last byte goes straight into the result
            if ((owner_q == OWN_READ) && at_last) begin
                mem_ctrl_load_to_mem <= asm_next;
            end
            if ((owner_q == OWN_FETCH) && !addr_moved && at_last) begin
                mem_ctrl_instru_to_if <= asm_next;
            end
        end
    end

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int MAX_RECORDS = 64;
    localparam int FIELDS      = 6;

    // op codes of the input file
    localparam logic [31:0] OP_STORE      = 32'd1;
    localparam logic [31:0] OP_LOAD       = 32'd2;
    localparam logic [31:0] OP_FETCH      = 32'd3;
    localparam logic [31:0] OP_FETCH_WAIT = 32'd4;

    logic            clk_in = 1'b0;
    logic            rst_in = 1'b1;
    logic            rdy_in = 1'b1;
    logic            cmd_valid = 1'b0;
    logic            cmd_write = 1'b0;
    mem_size_t       cmd_size = SIZE_W;
    logic            cmd_signed = 1'b0;
    logic [XLEN-1:0] cmd_addr = '0;
    logic [XLEN-1:0] cmd_wdata = '0;
    logic            pc_load = 1'b0;
    logic [XLEN-1:0] pc_value = '0;
    logic            fetch_en = 1'b0;
    logic            lsu_busy;
    logic            lsu_done;
    logic [XLEN-1:0] lsu_rdata;
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] instr_pc;

    logic [31:0] stim [MAX_RECORDS*FIELDS];
    logic [7:0]  ref_mem [4096];
    integer      seed = 32'h06bf82a6;
    int          num_records = 0;
    logic        records_ready = 1'b0;
    // fetch run handed from the main flow to the instruction monitor
    logic [31:0] run_pc = '0;
    int          run_count = 0;
    int          run_id = 0;
    int          seen_id = 0;
    logic [31:0] fetch_pc = '0;
    int          fetch_left = 0;

    mem_subsys_top #(.RAM_ADDR_W(12)) dut_i (.*);

    always #20 clk_in = ~clk_in;

    // random stalls once out of reset
    always @(negedge clk_in) begin
        rdy_in = rst_in ? 1'b1 : (($random(seed) & 3) != 0);
    end

    task automatic stop_on_error;
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // little-endian bytes from the reference memory
    function automatic logic [31:0] model_load(input logic [31:0] addr, input int size,
                                               input logic sgn);
        logic [31:0] word;
        logic [11:0] a;
        word = '0;
        for (int k = 0; k < size; k++) begin
            a = addr[11:0] + 12'(k);
            word[8*k +: 8] = ref_mem[a];
        end
        if (sgn && size < 4 && word[8*size-1]) begin
            word = word | (32'hffffffff << (8 * size));
        end
        return word;
    endfunction

    task automatic write_model(input logic [31:0] addr, input int size,
                               input logic [31:0] data);
        logic [11:0] a;
        for (int k = 0; k < size; k++) begin
            a = addr[11:0] + 12'(k);
            ref_mem[a] = data[8*k +: 8];
        end
    endtask

    task automatic run_data_op(input logic wr, input logic [2:0] size, input logic sgn,
                               input logic [31:0] addr, input logic [31:0] data,
                               output logic [31:0] result);
        @(negedge clk_in);
        while (lsu_busy) @(negedge clk_in);
        cmd_valid  = 1'b1;
        cmd_write  = wr;
        cmd_size   = mem_size_t'(size);
        cmd_signed = sgn;
        cmd_addr   = addr;
        cmd_wdata  = data;
        @(negedge clk_in);
        cmd_valid = 1'b0;
        while (!lsu_done) @(negedge clk_in);
        result = lsu_rdata;
    endtask

    // instruction monitor that picks up a new run when run_id moves
    always @(posedge clk_in) begin : check_fetch
        if (seen_id != run_id) begin
            seen_id    = run_id;
            fetch_pc   = run_pc;
            fetch_left = run_count;
        end
        if (instr_valid && fetch_left != 0) begin
            check_value("instr_pc", instr_pc, fetch_pc);
            check_value("instr", instr, model_load(fetch_pc, 4, 1'b0));
            fetch_pc   = fetch_pc + 32'd4;
            fetch_left = fetch_left - 1;
        end
    end

    initial begin
        wait (records_ready);
        repeat (num_records * 64 + 16) @(posedge clk_in);
        $display("timeout: the run did not finish within the time for %0d records",
                 num_records);
        stop_on_error();
    end

    initial begin
        logic [31:0] op;
        logic [31:0] size;
        logic [31:0] sgn;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] result;
        logic [31:0] expected;

        for (int k = 0; k < MAX_RECORDS * FIELDS; k++) begin
            stim[k] = '0;
        end
        for (int k = 0; k < 4096; k++) begin
            ref_mem[k] = '0;
        end
        $readmemh("mem_subsys_input.txt", stim);
        while (num_records < MAX_RECORDS && stim[num_records*FIELDS] != 0) begin
            num_records++;
        end
        records_ready = 1'b1;

        repeat (16) @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);
        assert (!lsu_busy && !lsu_done && !instr_valid) else begin
            $display("outputs were not idle after reset");
            stop_on_error();
        end

        for (int r = 0; r < num_records; r++) begin
            op   = stim[r*FIELDS];
            size = stim[r*FIELDS+1];
            sgn  = stim[r*FIELDS+2];
            addr = stim[r*FIELDS+4];
            data = stim[r*FIELDS+5];
            case (op)
                OP_STORE: begin
                    run_data_op(1'b1, size[2:0], 1'b0, addr, data, result);
                    write_model(addr, int'(size), data);
                    check_value($sformatf("store record %0d", r), result, '0);
                end
                OP_LOAD, OP_FETCH: begin
                    expected = model_load(addr, (op == OP_LOAD) ? int'(size) : 4, sgn[0]);
                    assert (expected == data) else begin
                        $display("input file record %0d does not match the reference memory", r);
                        stop_on_error();
                    end
                    if (op == OP_LOAD) begin
                        run_data_op(1'b0, size[2:0], sgn[0], addr, '0, result);
                        check_value($sformatf("load record %0d", r), result, expected);
                    end else begin
                        @(negedge clk_in);
                        pc_load  = 1'b1;
                        pc_value = addr;
                        fetch_en = 1'b1;
                        @(negedge clk_in);
                        pc_load   = 1'b0;
                        run_pc    = addr;
                        run_count = int'(stim[r*FIELDS+3]);
                        run_id++;
                    end
                end
                OP_FETCH_WAIT: begin
                    while (seen_id != run_id || fetch_left != 0) @(negedge clk_in);
                    fetch_en = 1'b0;
                end
                default: begin
                    $display("input file record %0d has an unknown op code", r);
                    stop_on_error();
                end
            endcase
        end

        if (num_records > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("no records were run from the input file");
            stop_on_error();
        end
    end

endmodule

// File: tb_mem_subsys_assertions.sv
`timescale 1ns/10ps

module memctrl_assertions (
    input logic       clk_in,
    input logic       rst_in,
    input logic       rdy_in,
    input logic       r_or_w,
    input logic       mem_load_done,
    input logic       if_load_done,
    input logic [1:0] mem_ctrl_busy_state
);
    import mem_pkg::*;

    // RAM writes only while not stalled
    no_write_in_stall: assert property (
        @(posedge clk_in) disable iff (rst_in) !rdy_in |-> !r_or_w
    ) else $error("r_or_w high while rdy_in is low");

    mem_done_single: assert property (
        @(posedge clk_in) disable iff (rst_in) mem_load_done |=> !mem_load_done
    ) else $error("mem_load_done longer than one cycle");

    if_done_single: assert property (
        @(posedge clk_in) disable iff (rst_in) if_load_done |=> !if_load_done
    ) else $error("if_load_done longer than one cycle");

    done_exclusive: assert property (
        @(posedge clk_in) disable iff (rst_in) !(mem_load_done && if_load_done)
    ) else $error("both done pulses in the same cycle");

    // only one owner of the RAM port at a time
    busy_exclusive: assert property (
        @(posedge clk_in) disable iff (rst_in)
            !(mem_ctrl_busy_state[BUSY_IF] && mem_ctrl_busy_state[BUSY_MEM])
    ) else $error("busy state shows fetch and data at once");

endmodule

bind memctrl memctrl_assertions memctrl_assertions_i (
    .clk_in              (clk_in),
    .rst_in              (rst_in),
    .rdy_in              (rdy_in),
    .r_or_w              (r_or_w),
    .mem_load_done       (mem_load_done),
    .if_load_done        (if_load_done),
    .mem_ctrl_busy_state (mem_ctrl_busy_state)
);

// File: verilog.f
mem_pkg.sv
byte_ram.sv
memctrl.sv
fetch_unit.sv
load_store_unit.sv
mem_subsys_top.sv
tb_mem_subsys_assertions.sv
tb_mem_subsys.sv
